// File: hw/uart_rx_defs.svh
// bit-timing constants assume 16 ticks per bit; the check points must stay below UART_OVERSAMPLE
`ifndef UART_RX_DEFS_SVH
`define UART_RX_DEFS_SVH

// --------------------
// oversampling
// --------------------
`define UART_OVERSAMPLE 16 // baud ticks per bit

// low ticks in idle before the start bit is accepted, roughly mid start bit
`define UART_START_CHECK 8

`define UART_SAMPLE_POINT 15 // data, parity and stop sampling tick
`define UART_STOP_CHECK 14 // framing check and frame emit in stop state

// ticks to wait for the line to go high again after a frame
`define UART_WAIT_LIMIT 6

// --------------------
// glitch filter
// --------------------
`define UART_FILTER_TAPS 3 // odd depth keeps the vote unambiguous

`endif

// File: hw/uart_rx_pkg.sv
// shared receive types only; the struct layouts are fixed and the status bit order is host visible
`default_nettype none

package uart_rx_pkg;

  // --------------------
  // receive FSM
  // --------------------
  typedef enum logic [1:0]
  {
    RX_IDLE = 2'd0, // hunting for a start bit
    RX_DATA = 2'd1, // data bits and optional parity bit
    RX_STOP = 2'd2, // stop bit check
    RX_WAIT = 2'd3  // line recovery before next start
  } rx_state_e;

  // line settings from the host, held stable during a frame
  typedef struct packed
  {
    logic bit8;       // 1 = eight data bits, 0 = seven
    logic parity_en;
    logic odd_parity; // 1 = odd, 0 = even
  } rx_cfg_t;

  typedef struct packed
  {
    logic level; // majority filtered rx
    logic tick;  // baud tick aligned with level
  } rx_sample_t;

  // one clock wide result per received frame
  typedef struct packed
  {
    logic       valid;
    logic [7:0] data;
    logic       parity_err;
    logic       framing_err;
  } rx_frame_t;

  typedef struct packed
  {
    logic full;
    logic overflow;
    logic parity_err;
    logic framing_err;
  } rx_status_t;

endpackage

`default_nettype wire

// File: hw/rx_glitch_filter.sv
// rx is sampled only on baud_tick and must already be synchronised to clk outside this block
`timescale 1ns/10ps
`default_nettype none

`include "uart_rx_defs.svh"

module rx_glitch_filter
  import uart_rx_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  wire        baud_tick,
  input  wire        rx,
  output rx_sample_t sample
);

  localparam int TAPS = `UART_FILTER_TAPS;

  logic [TAPS-1:0] taps_q;  // newest sample in the msb
  logic [TAPS-1:0] taps_d;

  // more than half of the taps high gives a high level
  function automatic logic majority(input logic [TAPS-1:0] bits);
    int unsigned ones;
    ones = 0;
    for (int i = 0; i < TAPS; i++)
    begin
      ones += bits[i];
    end
    return (ones > TAPS / 2);
  endfunction

  assign taps_d = {rx, taps_q[TAPS-1:1]};

  // vote and tick leave together one cycle later so the decoder sees them in phase
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      taps_q       <= '1; // idle line is high
      sample.level <= 1'b1;
      sample.tick  <= 1'b0;
    end
    else
    begin
      sample.tick <= baud_tick;
      if (baud_tick)
      begin
        taps_q       <= taps_d;
        sample.level <= majority(taps_d);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rx_frame_decoder.sv
// cfg must stay stable from start bit to stop bit; a new start is only seen after the wait state
`timescale 1ns/10ps
`default_nettype none

`include "uart_rx_defs.svh"

module rx_frame_decoder
  import uart_rx_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  rx_sample_t sample,
  input  rx_cfg_t    cfg,
  output rx_frame_t  frame
);

  localparam int CNT_W = $clog2(`UART_OVERSAMPLE);

  localparam logic [CNT_W-1:0] START_CHECK  = CNT_W'(`UART_START_CHECK);
  localparam logic [CNT_W-1:0] SAMPLE_POINT = CNT_W'(`UART_SAMPLE_POINT);
  localparam logic [CNT_W-1:0] STOP_CHECK   = CNT_W'(`UART_STOP_CHECK);
  localparam logic [CNT_W-1:0] WAIT_LIMIT   = CNT_W'(`UART_WAIT_LIMIT);
  localparam logic [CNT_W-1:0] CNT_LAST     = CNT_W'(`UART_OVERSAMPLE - 1);

  rx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;     // ticks within the current bit
  logic [3:0]       bit_idx_q; // next bit to store
  rx_cfg_t          cfg_q;     // settings taken at start bit
  logic             par_acc_q; // xor of the data bits

  logic [8:0]       shift_q;   // data bits then parity, lsb first
  logic             frame_valid_q;
  logic [7:0]       frame_data_q;
  logic             frame_perr_q;
  logic             frame_ferr_q;

  logic [3:0]       data_bits;
  logic [3:0]       frame_bits;
  logic             par_bit;
  logic             sample_now;
  logic             stop_now;

  assign data_bits  = cfg_q.bit8 ? 4'd8 : 4'd7;
  assign frame_bits = data_bits + {3'b000, cfg_q.parity_en};
  assign par_bit    = cfg_q.bit8 ? shift_q[8] : shift_q[7];

  assign sample_now = sample.tick && (state_q == RX_DATA) && (cnt_q == SAMPLE_POINT);
  assign stop_now   = sample.tick && (state_q == RX_STOP) && (cnt_q == STOP_CHECK);

  // --------------------
  // FSM and bit timing
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      cfg_q     <= '0;
      par_acc_q <= 1'b0;
    end
    else if (sample.tick)
    begin
      case (state_q)
        RX_IDLE:
        begin
          if (sample.level)
          begin
            cnt_q <= '0; // glitch or idle, start over
          end
          else if (cnt_q == START_CHECK)
          begin
            state_q   <= RX_DATA;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            cfg_q     <= cfg;
            par_acc_q <= 1'b0;
          end
          else
          begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA:
        begin
          cnt_q <= (cnt_q == CNT_LAST) ? '0 : cnt_q + 1'b1;
          if (cnt_q == SAMPLE_POINT)
          begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q < data_bits)
            begin
              par_acc_q <= par_acc_q ^ sample.level;
            end
            if (bit_idx_q == frame_bits - 4'd1)
            begin
              state_q <= RX_STOP; // last data or parity bit
            end
          end
        end
        RX_STOP:
        begin
          if (cnt_q == STOP_CHECK)
          begin
            state_q <= RX_WAIT;
            cnt_q   <= '0;
          end
          else
          begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_WAIT:
        begin
          if (sample.level || (cnt_q == WAIT_LIMIT))
          begin
            state_q <= RX_IDLE;
            cnt_q   <= '0;
          end
          else
          begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default:
        begin
          state_q <= RX_IDLE;
          cnt_q   <= '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      frame_valid_q <= 1'b0;
    end
    else
    begin
      frame_valid_q <= stop_now; // single clock pulse
    end
  end

  // --------------------
  // shift path and frame result
  // --------------------
  always_ff @(posedge clk)
  begin
    if (sample_now)
    begin
      shift_q[bit_idx_q] <= sample.level;
    end
    if (stop_now)
    begin
      frame_data_q <= {cfg_q.bit8 & shift_q[7], shift_q[6:0]}; // bit 7 zero in 7-bit mode
      // even parity wants an even count of ones over data and parity bit
      frame_perr_q <= cfg_q.parity_en & (par_acc_q ^ par_bit ^ cfg_q.odd_parity);
      frame_ferr_q <= ~sample.level; // stop bit must be high
    end
  end

  assign frame.valid       = frame_valid_q;
  assign frame.data        = frame_data_q;
  assign frame.parity_err  = frame_perr_q;
  assign frame.framing_err = frame_ferr_q;

endmodule

`default_nettype wire

// File: hw/rx_holding_reg.sv
// single byte buffer; a frame that meets a full register is lost and only overflow records it
`timescale 1ns/10ps
`default_nettype none

module rx_holding_reg
  import uart_rx_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  rx_frame_t  frame,
  input  wire        read,
  output logic [7:0] rx_byte,
  output rx_status_t status
);

  logic space; // room for a new byte this cycle

  // a read in the same cycle frees the register for the arriving frame
  assign space = !status.full || read;

  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_byte <= '0;
      status  <= '0;
    end
    else
    begin
      // --------------------
      // host read
      // --------------------
      if (read)
      begin
        status.overflow <= 1'b0;
        if (status.full)
        begin
          status.full        <= 1'b0;
          status.parity_err  <= 1'b0;
          status.framing_err <= 1'b0;
        end
      end

      // new frame from the decoder
      if (frame.valid)
      begin
        if (space)
        begin
          rx_byte            <= frame.data;
          status.full        <= 1'b1;
          status.parity_err  <= frame.parity_err;
          status.framing_err <= frame.framing_err;
        end
        else
        begin
          status.overflow <= 1'b1; // sticky until the next read
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/uart_rx_top.sv
// rx must be synchronised to clk and baud_tick must be one clock wide at 16 ticks per bit
`timescale 1ns/10ps
`default_nettype none

module uart_rx_top
  import uart_rx_pkg::*;
(
  input  wire        clk,
  input  wire        aresetn,
  input  wire        baud_tick,
  input  wire        rx,
  input  rx_cfg_t    cfg,
  input  wire        read,
  output logic [7:0] rx_byte,
  output rx_status_t status
);

  rx_sample_t sample; // filtered line with tick
  rx_frame_t  frame;  // one clock frame result

  // --------------------
  // stage 1, glitch filter
  // --------------------
  rx_glitch_filter u_rx_glitch_filter
  (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_tick (baud_tick),
    .rx        (rx),
    .sample    (sample)
  );

  // stage 2, frame decoder
  rx_frame_decoder u_rx_frame_decoder
  (
    .clk     (clk),
    .aresetn (aresetn),
    .sample  (sample),
    .cfg     (cfg),
    .frame   (frame)
  );

  // stage 3, holding register with host handshake
  rx_holding_reg u_rx_holding_reg
  (
    .clk     (clk),
    .aresetn (aresetn),
    .frame   (frame),
    .read    (read),
    .rx_byte (rx_byte),
    .status  (status)
  );

endmodule

`default_nettype wire

// File: verif/tb_uart_rx.sv
// run from the project root so the vector file is found; baud tick fixed at one clock in four
`timescale 1ns/10ps
`default_nettype none

`include "uart_rx_defs.svh"

module tb_uart_rx
  import uart_rx_pkg::*;
();

  localparam int CLK_HALF_NS      = 50;
  localparam int TICK_CLKS        = 4; // clocks per baud tick
  localparam int BIT_CLKS         = `UART_OVERSAMPLE * TICK_CLKS;
  localparam int NUM_VECTORS      = 21;
  localparam int FULL_WAIT        = 4 * BIT_CLKS; // clocks allowed for full to rise
  localparam int GLITCH_IDLE_BITS = 12; // longer than any frame a false start could make
  localparam int FRAME_BITS_MAX   = 16; // start, 8 data, parity, stop and up to 5 idle bits
  localparam int VECTOR_BITS_MAX  = FRAME_BITS_MAX + GLITCH_IDLE_BITS + 1;
  localparam int WATCHDOG_NS      = (NUM_VECTORS + 1) * VECTOR_BITS_MAX * BIT_CLKS
                                    * 2 * CLK_HALF_NS;

  logic        clk;
  logic        aresetn;
  logic        baud_tick;
  logic        rx;
  rx_cfg_t     cfg;
  logic        read;
  logic [7:0]  rx_byte;
  rx_status_t  status;

  logic [1:0]  tick_div;
  logic [31:0] vectors [0:NUM_VECTORS-1];

  uart_rx_top u_uart_rx_top
  (
    .clk       (clk),
    .aresetn   (aresetn),
    .baud_tick (baud_tick),
    .rx        (rx),
    .cfg       (cfg),
    .read      (read),
    .rx_byte   (rx_byte),
    .status    (status)
  );

  always #(CLK_HALF_NS) clk = ~clk;

  // one clock wide tick every TICK_CLKS clocks
  always @(negedge clk)
  begin
    tick_div  <= tick_div + 2'd1;
    baud_tick <= (tick_div == 2'(TICK_CLKS - 1));
  end

  // --------------------
  // checks
  // --------------------
  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected)
    begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected 8'h%02h, got 8'h%02h",
                              $time, name, expected, actual));
    end
  endtask

  // status bits are full, overflow, parity_err, framing_err
  task automatic check_status(input string name, input rx_status_t expected,
                              input rx_status_t actual);
    if (actual !== expected)
    begin
      stop_on_error($sformatf("mismatch at %0t ns: %s expected 4'b%04b, got 4'b%04b",
                              $time, name, expected, actual));
    end
  endtask

  // --------------------
  // line and host drivers
  // --------------------
  task automatic drive_bit(input logic level);
    rx = level;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  task automatic send_frame(input rx_cfg_t c, input logic [7:0] data,
                            input logic flip, input logic bad_stop);
    int   nbits;
    int   gap;
    logic par;
    nbits = c.bit8 ? 8 : 7;
    gap   = $urandom % 4; // extra idle bits
    par   = c.odd_parity; // odd parity starts from one
    drive_bit(1'b0);
    for (int i = 0; i < nbits; i++)
    begin
      drive_bit(data[i]); // lsb first
      par = par ^ data[i];
    end
    if (c.parity_en)
    begin
      drive_bit(par ^ flip);
    end
    drive_bit(!bad_stop);
    repeat (2 + gap) drive_bit(1'b1);
  endtask

  task automatic inject_glitch();
    rx = 1'b0;
    repeat (TICK_CLKS) @(negedge clk); // low for exactly one tick
    repeat (GLITCH_IDLE_BITS) drive_bit(1'b1); // a false frame would land in this window
  endtask

  task automatic wait_full();
    int waited;
    waited = 0;
    while (!status.full && waited < FULL_WAIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!status.full)
    begin
      stop_on_error("timeout: full never rose after a frame was sent");
    end
  endtask

  task automatic pulse_read();
    read = 1'b1;
    @(negedge clk);
    read = 1'b0; // register already emptied at the edge between
  endtask

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    stop_on_error("watchdog: the run did not finish within its time limit");
  end

  initial
  begin
    logic [31:0] vec;
    rx_cfg_t     vcfg;
    logic [7:0]  vdata;
    logic [3:0]  faults;
    logic [7:0]  exp_byte;
    rx_status_t  exp_status;
    clk       = 1'b0;
    aresetn   = 1'b0;
    baud_tick = 1'b0;
    tick_div  = 2'd0;
    rx        = 1'b1;
    cfg       = '0;
    read      = 1'b0;
    void'($urandom(32'h0650_303c));
    $readmemh("verif/uart_rx_vectors.txt", vectors);

    repeat (4) @(posedge clk);
    @(negedge clk);
    aresetn = 1'b1;
    drive_bit(1'b1); // idle line before the first frame

    for (int v = 0; v < NUM_VECTORS; v++)
    begin
      vec                    = vectors[v];
      vcfg                   = rx_cfg_t'(vec[30:28]);
      vdata                  = vec[27:20];
      faults                 = vec[19:16];
      exp_byte               = vec[11:4];
      exp_status.full        = 1'b1;
      exp_status.overflow    = vec[0];
      exp_status.parity_err  = vec[2];
      exp_status.framing_err = vec[1];
      cfg                    = vcfg;
      if (faults[2])
      begin
        inject_glitch();
        check_status("status after glitch", '0, status); // filter must swallow it
      end
      send_frame(vcfg, vdata, faults[0], faults[1]);
      wait_full();
      check_byte("rx_byte", exp_byte, rx_byte);
      check_status("status", exp_status, status);
      if (vec[12])
      begin
        pulse_read();
        check_status("status after read", '0, status);
        check_byte("rx_byte after read", exp_byte, rx_byte);
      end
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/uart_rx_pkg.sv
hw/rx_glitch_filter.sv
hw/rx_frame_decoder.sv
hw/rx_holding_reg.sv
hw/uart_rx_top.sv
verif/tb_uart_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the UART receiver testbench with Verilator and run it, the exit status is the verdict
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_uart_rx \
  -f compile.f \
  -o tb_uart_rx

./obj_dir/tb_uart_rx

// File: verif/uart_rx_vectors.txt
// columns, one hex digit each unless noted: cfg {bit8,parity_en,odd}, data (2), faults {glitch,bad_stop,flip_par},
// read after frame, expected rx_byte (2), expected flags {parity_err,framing_err,overflow}
// eight bits, no parity
4A501A50
43C013C0
40001000
4FF01FF0
// parity modes, seven bit data returns bit 7 as zero
2C501450
23311334
75A015A0
78111814
69601960
37F117F4
// low stop bit still delivers the byte
46621662
20F310F6
70121012
// overflow pairs, the first frame is kept and the second is dropped
41100110
42201111
// one tick glitch on the idle line first, only after a row that reads
45E415E0
7C341C30
64410444
49921445
08001000
02A012A0
